// File: Bender.yml
package:
  name: rv64_sim_top

sources:
  - rtl/core_pkg.sv
  - rtl/core_if.sv
  - rtl/word_ram.sv
  - rtl/fetch_decode.sv
  - rtl/execute_unit.sv
  - rtl/commit_unit.sv
  - rtl/sim_top.sv
  - target: simulation
    files:
      - bench/sim_top_props.sv
      - bench/tb_sim_top.sv

// File: bench/sim_top_props.sv
`timescale 1ns/1ps

module sim_top_props import core_pkg::*; (
  input logic            clock,
  input logic            reset,
  input logic            commit_wen_i,
  input logic [4:0]      commit_wdest_i,
  input logic            trap_valid_i,
  input logic [xlen-1:0] instr_cnt_i
);

  // x0 is never a write destination.
  wdest_nonzero: assert property (@(posedge clock) disable iff (reset)
    commit_wen_i |-> commit_wdest_i != 5'd0)
    else $error("commit write enable set with destination x0");

  trap_sticky: assert property (@(posedge clock) disable iff (reset)
    trap_valid_i |=> trap_valid_i)
    else $error("trap valid dropped after it was set");

  cnt_monotonic: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> instr_cnt_i >= $past(instr_cnt_i))
    else $error("retired instruction count went down");

endmodule

bind sim_top sim_top_props u_sim_top_props (
  .clock          (clock),
  .reset          (reset),
  .commit_wen_i   (commit_wen_o),
  .commit_wdest_i (commit_wdest_o),
  .trap_valid_i   (trap_valid_o),
  .instr_cnt_i    (instr_cnt_o)
);

// File: bench/tb_sim_top.sv
`timescale 1ns/1ps

module tb_sim_top import core_pkg::*; ();

  localparam int prog_len       = 48;
  localparam int max_instr      = 64;
  localparam int timeout_cycles = max_instr * 8 + 200;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic            wen;
    logic [4:0]      wdest;
    logic [xlen-1:0] wdata;
  } commit_t;

  logic               clock = 1'b0;
  logic               reset;
  logic               load_en;
  logic [iram_aw-1:0] load_addr;
  logic [31:0]        load_data;
  logic               commit_valid;
  logic [xlen-1:0]    commit_pc;
  logic [31:0]        commit_inst;
  logic               commit_wen;
  logic [4:0]         commit_wdest;
  logic [xlen-1:0]    commit_wdata;
  logic               trap_valid;
  logic [7:0]         trap_code;
  logic [xlen-1:0]    cycle_cnt;
  logic [xlen-1:0]    instr_cnt;

  inst_word_u prog [prog_len+1];
  commit_t    exp_q [$];
  logic [7:0] exp_code;
  int         exp_retired;
  int         exp_cycles;
  int         checks;
  int         errors;
  logic       trap_seen;

  always #4 clock = ~clock;

  sim_top u_sim_top (
    .clock          (clock),
    .reset          (reset),
    .load_en_i      (load_en),
    .load_addr_i    (load_addr),
    .load_data_i    (load_data),
    .commit_valid_o (commit_valid),
    .commit_pc_o    (commit_pc),
    .commit_inst_o  (commit_inst),
    .commit_wen_o   (commit_wen),
    .commit_wdest_o (commit_wdest),
    .commit_wdata_o (commit_wdata),
    .trap_valid_o   (trap_valid),
    .trap_code_o    (trap_code),
    .cycle_cnt_o    (cycle_cnt),
    .instr_cnt_o    (instr_cnt)
  );

  function automatic logic [xlen-1:0] sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  task automatic check_field(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [11:0] moff;
    logic [12:0] boff;
    int          kind;
    for (int i = 0; i < prog_len; i++) begin
      // the first four stores give every used data word a known value.
      kind = (i < 4) ? 6 : int'($urandom % 8);
      rd   = 5'($urandom % 12);
      rs1  = 5'($urandom % 12);
      rs2  = 5'($urandom % 12);
      imm  = 12'($urandom);
      moff = (i < 4) ? 12'(i * 8) : 12'(($urandom % 4) * 8);
      // forward only, at most up to the trap.
      boff = 13'(4 * (1 + $urandom % (prog_len - i)));
      case (kind)
        0: prog[i] = {imm, rs1, 3'd0, rd, op_imm};
        1: prog[i] = {7'h00, rs2, rs1, 3'd0, rd, op_reg};
        2: prog[i] = {7'h20, rs2, rs1, 3'd0, rd, op_reg};
        3: prog[i] = {7'h00, rs2, rs1, 3'd4, rd, op_reg};
        4: prog[i] = {20'($urandom), rd, op_lui};
        5: prog[i] = {moff, 5'd0, 3'd3, rd, op_load};
        6: prog[i] = {moff[11:5], rs2, 5'd0, 3'd3, moff[4:0], op_store};
        default: prog[i] = {boff[12], boff[10:5], rs2, rs1, 3'd1, boff[4:1], boff[11], op_branch};
      endcase
    end
    prog[prog_len] = {25'd0, op_trap};
  endtask

  task automatic run_model();
    logic [xlen-1:0] xr [32];
    logic [xlen-1:0] dm [2**dram_aw];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] addr;
    logic            wr;
    inst_word_u      w;
    commit_t         c;
    for (int r = 0; r < 32; r++) begin
      xr[r] = '0;
    end
    pc = pc_start;
    exp_retired = 0;
    for (int n = 0; n < max_instr; n++) begin
      w      = prog[(pc - pc_start) >> 2];
      a      = xr[w.r.rs1];
      b      = xr[w.r.rs2];
      c      = '0;
      c.pc   = pc;
      c.inst = w;
      wr     = 1'b0;
      pc     = pc + 64'd4;
      case (w.r.opcode)
        op_imm: begin
          wr      = 1'b1;
          c.wdata = a + sext12(w[31:20]);
        end
        op_reg: begin
          wr = 1'b1;
          case ({w.r.funct7, w.r.funct3})
            {7'h00, 3'd0}: c.wdata = a + b;
            {7'h20, 3'd0}: c.wdata = a - b;
            default:       c.wdata = a ^ b;
          endcase
        end
        op_lui: begin
          wr      = 1'b1;
          c.wdata = {{32{w[31]}}, w[31:12], 12'h000};
        end
        op_load: begin
          wr      = 1'b1;
          addr    = a + sext12(w[31:20]);
          c.wdata = dm[addr[dram_aw+2:3]];
        end
        op_store: begin
          addr = a + sext12({w.s.imm_hi, w.s.imm_lo});
          dm[addr[dram_aw+2:3]] = b;
        end
        op_branch: begin
          if (a != b) pc = c.pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        default: ;
      endcase
      c.wen   = wr && (w.r.rd != 5'd0);
      c.wdest = wr ? w.r.rd : 5'd0;
      if (c.wen) xr[w.r.rd] = c.wdata;
      exp_q.push_back(c);
      exp_retired++;
      if (w.r.opcode == op_trap) begin
        exp_code = xr[10][7:0];
        break;
      end
    end
  endtask

  // clock edges seen out of reset, up to and including the trap edge.
  always @(posedge clock) begin
    if (!reset && !trap_seen) begin
      exp_cycles++;
    end
  end

  always @(negedge clock) begin
    commit_t c;
    if (!reset && commit_valid) begin
      assert (!trap_seen) else begin
        errors++;
        $display("commit at pc %h arrived after the trap", commit_pc);
      end
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("commit at pc %h but the model has no instruction left", commit_pc);
      end
      if (exp_q.size() > 0) begin
        c = exp_q.pop_front();
        check_field("commit_pc_o", commit_pc, c.pc);
        check_field("commit_inst_o", commit_inst, c.inst);
        check_field("commit_wen_o", commit_wen, c.wen);
        check_field("commit_wdest_o", commit_wdest, c.wdest);
        if (c.wen) check_field("commit_wdata_o", commit_wdata, c.wdata);
      end
    end
    if (!reset && trap_valid && !trap_seen) begin
      trap_seen = 1'b1;
      check_field("trap_code_o", trap_code, exp_code);
      check_field("instr_cnt_o", instr_cnt, exp_retired);
      check_field("cycle_cnt_o", cycle_cnt, exp_cycles);
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("timeout after %0d cycles with no trap from the core", timeout_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    checks     = 0;
    errors     = 0;
    exp_cycles = 0;
    trap_seen  = 1'b0;
    void'($urandom(32'hbf95_5f94));
    build_program();
    run_model();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    // the core stays parked while the program is written.
    for (int i = 0; i <= prog_len; i++) begin
      load_en   <= 1'b1;
      load_addr <= iram_aw'(i);
      load_data <= prog[i];
      @(posedge clock);
    end
    load_en <= 1'b0;
    wait (trap_seen);
    // quiet window, nothing may commit after the trap.
    repeat (20) @(posedge clock);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d predicted commits never appeared", exp_q.size());
    end
    // both counters hold their trap values.
    check_field("cycle_cnt_o", cycle_cnt, exp_cycles);
    check_field("instr_cnt_o", instr_cnt, exp_retired);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
rtl/core_pkg.sv
rtl/core_if.sv
rtl/word_ram.sv
rtl/fetch_decode.sv
rtl/execute_unit.sv
rtl/commit_unit.sv
rtl/sim_top.sv
bench/sim_top_props.sv
bench/tb_sim_top.sv

// File: rtl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  exe_res_if.rx           res,
  reg_read_if.server      regs,
  output logic            done_o,
  output logic            redirect_o,
  output logic [xlen-1:0] target_o,
  output logic            trap_o,
  output logic            commit_valid_o,
  output logic [xlen-1:0] commit_pc_o,
  output logic [31:0]     commit_inst_o,
  output logic            commit_wen_o,
  output logic [4:0]      commit_wdest_o,
  output logic [xlen-1:0] commit_wdata_o,
  output logic            trap_valid_o,
  output logic [7:0]      trap_code_o,
  output logic [xlen-1:0] cycle_cnt_o,
  output logic [xlen-1:0] instr_cnt_o
);

  logic [xlen-1:0] rf [1:31];
  inst_word_u      res_inst;
  logic            retire;
  logic            is_trap;

  assign res_inst = res.inst;
  assign retire   = res.valid && !trap_valid_o;
  assign is_trap  = (res_inst.r.opcode == op_trap);
  assign trap_o   = trap_valid_o;

  // x0 is hardwired to zero.
  assign regs.rs1_data = (regs.rs1_addr == 5'd0) ? '0 : rf[regs.rs1_addr];
  assign regs.rs2_data = (regs.rs2_addr == 5'd0) ? '0 : rf[regs.rs2_addr];

  // architectural registers start at zero.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (retire && res.wen && res.rd != 5'd0) begin
      rf[res.rd] <= res.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid_o <= 1'b0;
      commit_wen_o   <= 1'b0;
      done_o         <= 1'b0;
      trap_valid_o   <= 1'b0;
      trap_code_o    <= 8'd0;
      cycle_cnt_o    <= '0;
      instr_cnt_o    <= '0;
    end else begin
      commit_valid_o <= retire;
      commit_wen_o   <= retire && res.wen;
      done_o         <= retire;
      if (!trap_valid_o) cycle_cnt_o <= cycle_cnt_o + 64'd1;
      if (retire) begin
        instr_cnt_o <= instr_cnt_o + 64'd1;
        if (is_trap) begin
          trap_valid_o <= 1'b1;
          trap_code_o  <= rf[10][7:0];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (retire) begin
      commit_pc_o    <= res.pc;
      commit_inst_o  <= res.inst;
      commit_wdest_o <= res.rd;
      commit_wdata_o <= res.wdata;
      redirect_o     <= res.redirect;
      target_o       <= res.target;
    end
  end

endmodule

// File: rtl/core_if.sv
`timescale 1ns/1ps

interface reg_read_if import core_pkg::*; ();
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  modport client (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
  modport server (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

interface dec_exe_if import core_pkg::*; ();
  logic            valid;
  logic [3:0]      op;
  logic [xlen-1:0] pc;
  logic [31:0]     inst;
  logic [4:0]      rd;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] imm;

  modport tx (output valid, op, pc, inst, rd, rs1_val, rs2_val, imm);
  modport rx (input valid, op, pc, inst, rd, rs1_val, rs2_val, imm);
endinterface

interface exe_res_if import core_pkg::*; ();
  logic            valid;
  logic [xlen-1:0] pc;
  logic [31:0]     inst;
  logic            wen;
  logic [4:0]      rd;
  logic [xlen-1:0] wdata;
  logic            redirect;
  logic [xlen-1:0] target;

  modport tx (output valid, pc, inst, wen, rd, wdata, redirect, target);
  modport rx (input valid, pc, inst, wen, rd, wdata, redirect, target);
endinterface

// File: rtl/core_pkg.sv
package core_pkg;

  localparam int xlen = 64;
  localparam logic [xlen-1:0] pc_start = 64'h8000_0000;
  localparam int iram_aw = 8;
  localparam int dram_aw = 6;

  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_reg    = 7'h33;
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_load   = 7'h03;
  localparam logic [6:0] op_store  = 7'h23;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_trap   = 7'h6b;

  // decoded operation field.
  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_xor  = 4'd2;
  localparam logic [3:0] alu_lui  = 4'd3;
  localparam logic [3:0] mem_ld   = 4'd4;
  localparam logic [3:0] mem_sd   = 4'd5;
  localparam logic [3:0] br_ne    = 4'd6;
  localparam logic [3:0] sys_trap = 4'd7;
  localparam logic [3:0] nop      = 4'd8;

  // fetch and decode FSM states.
  localparam logic [1:0] st_fetch  = 2'd0;
  localparam logic [1:0] st_wait   = 2'd1;
  localparam logic [1:0] st_decode = 2'd2;
  localparam logic [1:0] st_idle   = 2'd3;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } inst_word_u;

endpackage

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  dec_exe_if.rx              dec,
  output logic               dmem_rd_en_o,
  output logic               dmem_wr_en_o,
  output logic [dram_aw-1:0] dmem_addr_o,
  output logic [xlen-1:0]    dmem_wdata_o,
  input  logic [xlen-1:0]    dmem_rdata_i,
  exe_res_if.tx              res
);

  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] eff_addr;
  logic            load_q;

  // register form takes rs2, immediate form takes imm.
  assign operand_b = (dec.inst[6:0] == op_reg) ? dec.rs2_val : dec.imm;

  always_comb begin
    case (dec.op)
      alu_add: alu_result = dec.rs1_val + operand_b;
      alu_sub: alu_result = dec.rs1_val - dec.rs2_val;
      alu_xor: alu_result = dec.rs1_val ^ dec.rs2_val;
      alu_lui: alu_result = dec.imm;
      default: alu_result = '0;
    endcase
  end

  assign eff_addr     = dec.rs1_val + dec.imm;
  assign dmem_addr_o  = eff_addr[dram_aw+2:3];
  assign dmem_rd_en_o = dec.valid && (dec.op == mem_ld);
  assign dmem_wr_en_o = dec.valid && (dec.op == mem_sd);
  assign dmem_wdata_o = dec.rs2_val;

  always_ff @(posedge clock) begin
    if (reset) begin
      load_q    <= 1'b0;
      res.valid <= 1'b0;
    end else begin
      load_q    <= dmem_rd_en_o;
      // loads retire one cycle late, once the data memory answers.
      res.valid <= (dec.valid && dec.op != mem_ld) || load_q;
    end
  end

  always_ff @(posedge clock) begin
    if (dec.valid) begin
      res.pc       <= dec.pc;
      res.inst     <= dec.inst;
      res.rd       <= dec.rd;
      res.wen      <= (dec.rd != 5'd0);
      res.wdata    <= alu_result;
      res.redirect <= (dec.op == br_ne) && (dec.rs1_val != dec.rs2_val);
      res.target   <= dec.pc + dec.imm;
    end else if (load_q) begin
      res.wdata <= dmem_rdata_i;
    end
  end

endmodule

// File: rtl/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode import core_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               hold_i,
  output logic               imem_rd_en_o,
  output logic [iram_aw-1:0] imem_addr_o,
  input  logic [31:0]        imem_data_i,
  input  logic               done_i,
  input  logic               redirect_i,
  input  logic [xlen-1:0]    target_i,
  input  logic               trap_i,
  reg_read_if.client         regs,
  dec_exe_if.tx              dec
);

  logic [1:0]      state_q;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_off;
  inst_word_u      inst_q;
  logic [3:0]      op_d;
  logic [4:0]      rd_d;
  logic [xlen-1:0] imm_d;

  always_ff @(posedge clock) begin
    if (reset || hold_i) begin
      state_q <= st_fetch;
      pc_q    <= pc_start;
    end else begin
      case (state_q)
        st_fetch:  state_q <= st_wait;
        st_wait:   state_q <= st_decode;
        st_decode: state_q <= st_idle;
        default: begin
          // a trap leaves the FSM parked here.
          if (done_i && !trap_i) begin
            state_q <= st_fetch;
            pc_q    <= redirect_i ? target_i : pc_q + 64'd4;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == st_wait) begin
      inst_q <= imem_data_i;
    end
  end

  assign pc_off       = pc_q - pc_start;
  assign imem_addr_o  = pc_off[iram_aw+1:2];
  assign imem_rd_en_o = (state_q == st_fetch);

  always_comb begin
    op_d  = nop;
    rd_d  = inst_q.r.rd;
    imm_d = {{52{inst_q.r.funct7[6]}}, inst_q.r.funct7, inst_q.r.rs2};
    case (inst_q.r.opcode)
      op_imm: begin
        if (inst_q.r.funct3 == 3'd0) op_d = alu_add;
      end
      op_reg: begin
        if (inst_q.r.funct3 == 3'd0 && inst_q.r.funct7 == 7'h00) op_d = alu_add;
        else if (inst_q.r.funct3 == 3'd0 && inst_q.r.funct7 == 7'h20) op_d = alu_sub;
        else if (inst_q.r.funct3 == 3'd4 && inst_q.r.funct7 == 7'h00) op_d = alu_xor;
      end
      op_lui: begin
        op_d  = alu_lui;
        imm_d = {{32{inst_q.r.funct7[6]}}, inst_q.r.funct7, inst_q.r.rs2,
                 inst_q.r.rs1, inst_q.r.funct3, 12'h000};
      end
      op_load: begin
        if (inst_q.r.funct3 == 3'd3) op_d = mem_ld;
      end
      op_store: begin
        if (inst_q.s.funct3 == 3'd3) op_d = mem_sd;
        imm_d = {{52{inst_q.s.imm_hi[6]}}, inst_q.s.imm_hi, inst_q.s.imm_lo};
      end
      op_branch: begin
        if (inst_q.s.funct3 == 3'd1) op_d = br_ne;
        imm_d = {{51{inst_q.s.imm_hi[6]}}, inst_q.s.imm_hi[6], inst_q.s.imm_lo[0],
                 inst_q.s.imm_hi[5:0], inst_q.s.imm_lo[4:1], 1'b0};
      end
      op_trap: op_d = sys_trap;
      default: op_d = nop;
    endcase
    // only register writers keep a destination.
    if (op_d == mem_sd || op_d == br_ne || op_d == sys_trap || op_d == nop) begin
      rd_d = 5'd0;
    end
  end

  assign regs.rs1_addr = inst_q.r.rs1;
  assign regs.rs2_addr = inst_q.r.rs2;

  assign dec.valid   = (state_q == st_decode);
  assign dec.op      = op_d;
  assign dec.pc      = pc_q;
  assign dec.inst    = inst_q;
  assign dec.rd      = rd_d;
  assign dec.rs1_val = regs.rs1_data;
  assign dec.rs2_val = regs.rs2_data;
  assign dec.imm     = imm_d;

endmodule

// File: rtl/sim_top.sv
`timescale 1ns/1ps

module sim_top import core_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               load_en_i,
  input  logic [iram_aw-1:0] load_addr_i,
  input  logic [31:0]        load_data_i,
  output logic               commit_valid_o,
  output logic [xlen-1:0]    commit_pc_o,
  output logic [31:0]        commit_inst_o,
  output logic               commit_wen_o,
  output logic [4:0]         commit_wdest_o,
  output logic [xlen-1:0]    commit_wdata_o,
  output logic               trap_valid_o,
  output logic [7:0]         trap_code_o,
  output logic [xlen-1:0]    cycle_cnt_o,
  output logic [xlen-1:0]    instr_cnt_o
);

  logic               imem_rd_en;
  logic [iram_aw-1:0] imem_addr;
  logic [31:0]        imem_data;
  logic               dmem_rd_en;
  logic               dmem_wr_en;
  logic [dram_aw-1:0] dmem_addr;
  logic [xlen-1:0]    dmem_wdata;
  logic [xlen-1:0]    dmem_rdata;
  logic               done;
  logic               redirect;
  logic [xlen-1:0]    target;
  logic               trap;

  reg_read_if regs_bus ();
  dec_exe_if  dec_bus ();
  exe_res_if  res_bus ();

  fetch_decode u_fetch_decode (
    .clock        (clock),
    .reset        (reset),
    .hold_i       (load_en_i),
    .imem_rd_en_o (imem_rd_en),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .done_i       (done),
    .redirect_i   (redirect),
    .target_i     (target),
    .trap_i       (trap),
    .regs         (regs_bus.client),
    .dec          (dec_bus.tx)
  );

  execute_unit u_execute_unit (
    .clock        (clock),
    .reset        (reset),
    .dec          (dec_bus.rx),
    .dmem_rd_en_o (dmem_rd_en),
    .dmem_wr_en_o (dmem_wr_en),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_rdata_i (dmem_rdata),
    .res          (res_bus.tx)
  );

  commit_unit u_commit_unit (
    .clock          (clock),
    .reset          (reset),
    .res            (res_bus.rx),
    .regs           (regs_bus.server),
    .done_o         (done),
    .redirect_o     (redirect),
    .target_o       (target),
    .trap_o         (trap),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wen_o   (commit_wen_o),
    .commit_wdest_o (commit_wdest_o),
    .commit_wdata_o (commit_wdata_o),
    .trap_valid_o   (trap_valid_o),
    .trap_code_o    (trap_code_o),
    .cycle_cnt_o    (cycle_cnt_o),
    .instr_cnt_o    (instr_cnt_o)
  );

  // program load uses the write side of the instruction memory.
  word_ram #(.width(32), .aw(iram_aw)) u_iram (
    .clock     (clock),
    .rd_en_i   (imem_rd_en),
    .rd_addr_i (imem_addr),
    .rd_data_o (imem_data),
    .wr_en_i   (load_en_i),
    .wr_addr_i (load_addr_i),
    .wr_data_i (load_data_i)
  );

  word_ram #(.width(xlen), .aw(dram_aw)) u_dram (
    .clock     (clock),
    .rd_en_i   (dmem_rd_en),
    .rd_addr_i (dmem_addr),
    .rd_data_o (dmem_rdata),
    .wr_en_i   (dmem_wr_en),
    .wr_addr_i (dmem_addr),
    .wr_data_i (dmem_wdata)
  );

endmodule

// File: rtl/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
  parameter int width = 32,
  parameter int aw    = 8
) (
  input  logic             clock,
  input  logic             rd_en_i,
  input  logic [aw-1:0]    rd_addr_i,
  output logic [width-1:0] rd_data_o,
  input  logic             wr_en_i,
  input  logic [aw-1:0]    wr_addr_i,
  input  logic [width-1:0] wr_data_i
);

  logic [width-1:0] mem [2**aw];

  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read before write on a shared address.
  always_ff @(posedge clock) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule
